// File: verif/bpf_exec_patterns.hex
// Columns: opcode jt jf k a x pc, then expected a, next pc, taken, unsup
// Order: ALU ops, MUL DIV MOD sentinels, conditional jumps, JA
0004 00 00 00000010 00000005 11111111 00000000 00000015 00000001 0 0
000C 00 00 77777777 FFFFFFFF 00000002 00000010 00000001 00000011 0 0
0014 00 00 00000001 00000000 22222222 00000020 FFFFFFFF 00000021 0 0
001C 00 00 12345678 00000100 00000010 00000022 000000F0 00000023 0 0
0044 00 00 0000F0F0 0F0F0000 FFFFFFFF 00000030 0F0FF0F0 00000031 0 0
004C 00 00 FFFFFFFF 80000000 00000001 00000031 80000001 00000032 0 0
0054 00 00 FF00FF00 12345678 00000000 00000040 12005600 00000041 0 0
005C 00 00 FFFFFFFF A5A5A5A5 0F0F0F0F 00000041 05050505 00000042 0 0
0064 00 00 00000004 12345678 00000040 00000050 23456780 00000051 0 0
006C 00 00 00000004 00000003 0000001F 00000051 80000000 00000052 0 0
0064 00 00 00000020 FFFFFFFF 00000001 00000052 00000000 00000053 0 0
006C 00 00 00000001 00000001 80000000 00000053 00000000 00000054 0 0
0074 00 00 00000008 87654321 00000000 00000060 00876543 00000061 0 0
007C 00 00 00000000 80000000 0000001F 00000061 00000001 00000062 0 0
0074 00 00 00000021 FFFFFFFF 00000001 00000062 00000000 00000063 0 0
0074 00 00 00000000 DEADBEEF 00000004 00000063 DEADBEEF 00000064 0 0
0084 00 00 FFFFFFFF 0F0F1234 00000000 00000070 F0F0EDCB 00000071 0 0
008C 00 00 00000000 00000000 12345678 00000071 FFFFFFFF 00000072 0 0
00A4 00 00 FFFF0000 12345678 00000000 00000080 EDCB5678 00000081 0 0
00AC 00 00 00000000 5A5A5A5A 5A5A5A5A 00000081 00000000 00000082 0 0
00B4 00 00 00000001 12345678 00000000 00000090 00000000 00000091 0 0
00FC 00 00 00000000 FFFFFFFF 00000001 00000091 00000000 00000092 0 0
0024 00 00 00000003 00000005 00000000 000000A0 CAFEDEAD 000000A1 0 1
002C 00 00 00000000 00000009 00000007 000000A1 CAFEDEAD 000000A2 0 1
0034 00 00 00000002 00000010 00000000 000000A2 DEADBEEF 000000A3 0 1
003C 00 00 00000000 00000010 00000004 000000A3 DEADBEEF 000000A4 0 1
0094 00 00 00000003 00000010 00000000 000000A4 BEEFCAFE 000000A5 0 1
009C 00 00 00000000 00000010 00000003 000000A5 BEEFCAFE 000000A6 0 1
0015 03 07 00000000 00000000 FFFFFFFF 00000100 00000000 00000104 1 0
001D 03 07 FFFFFFFF FFFFFFFF FFFFFFFE 00000110 FFFFFFFF 00000118 0 0
0025 01 02 7FFFFFFF 80000000 00000000 00000120 80000000 00000122 1 0
002D 01 02 00000000 FFFFFFFF FFFFFFFF 00000130 FFFFFFFF 00000133 0 0
0035 10 20 80000000 80000000 00000000 00000140 80000000 00000151 1 0
003D 10 20 00000000 7FFFFFFF 80000000 00000150 7FFFFFFF 00000171 0 0
0045 FF 00 80000000 80000001 00000000 00000160 80000001 00000260 1 0
004D FF 00 FFFFFFFF F0F0F0F0 0F0F0F0F 00000170 F0F0F0F0 00000171 0 0
0015 01 05 00000001 00000000 00000000 FFFFFFFE 00000000 00000004 0 0
0005 00 00 00000010 12345678 00000000 00000200 12345678 00000211 1 0
0005 05 09 FFFFFFFF 00000000 00000000 00000300 00000000 00000300 1 0

// File: sim.f
design/bpf_pkg.sv
design/bpf_alu.sv
design/bpf_branch.sv
design/bpf_commit.sv
design/bpf_exec.sv
verif/bpf_exec_tb.sv

// File: Makefile
# Verilator build and run of the BPF execute stage testbench

VERILATOR ?= verilator
TOP       ?= bpf_exec_tb
REG_STAGE ?= 1
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert -Wno-fatal

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove the build directory"
	@echo "  help   show this list"
	@echo "Variables: VERILATOR=$(VERILATOR) TOP=$(TOP) REG_STAGE=$(REG_STAGE)"
	@echo "           OBJ_DIR=$(OBJ_DIR) VFLAGS=$(VFLAGS)"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -GREG_STAGE=$(REG_STAGE) \
		--Mdir $(OBJ_DIR) -f sim.f
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
		echo "$$out"; \
		echo "$$out" | grep -qxF "TESTS PASSED"

clean:
	rm -rf $(OBJ_DIR)

// File: verif/bpf_exec_tb.sv
`timescale 1ns/10ps

module bpf_exec_tb
    import bpf_pkg::*;
#(
    parameter int REG_STAGE = 1                     // Handed down to the DUT
) ();

    localparam int NCOL    = 11;                    // Words per pattern line
    localparam int MAX_PAT = 64;
    localparam int C_OPC   = 0;
    localparam int C_JT    = 1;
    localparam int C_JF    = 2;
    localparam int C_K     = 3;
    localparam int C_A     = 4;
    localparam int C_X     = 5;
    localparam int C_PC    = 6;
    localparam int C_EA    = 7;                     // Expected accumulator
    localparam int C_EPC   = 8;                     // Expected next PC
    localparam int C_ET    = 9;
    localparam int C_EU    = 10;

    logic             clk;
    logic             reset_i;
    logic             in_valid_i;
    logic             in_ready_o;
    logic [OPC_W-1:0] opcode_i;
    logic [OFS_W-1:0] jt_i;
    logic [OFS_W-1:0] jf_i;
    logic [XLEN-1:0]  k_i;
    logic [XLEN-1:0]  a_i;
    logic [XLEN-1:0]  x_i;
    logic [XLEN-1:0]  pc_i;
    logic             out_valid_o;
    logic             out_ready_i;
    logic [XLEN-1:0]  out_a_o;
    logic [XLEN-1:0]  out_pc_o;
    logic             out_taken_o;
    logic             out_unsup_o;

    logic [31:0]     pat_mem [NCOL*MAX_PAT];
    logic [31:0]     rng;
    logic            loaded = 1'b0;
    logic            offering;                      // Current item stays on the input until taken
    logic            stalled;                       // Output was held back at the last sample
    logic [XLEN-1:0] held_a;
    logic [XLEN-1:0] held_pc;
    logic [1:0]      held_flags;                    // {taken, unsup} seen while stalled
    int              n_pat;
    int              sent;
    int              recv;
    int              errors;
    int              checks;
    int              hs_err;                        // Stall and drain errors
    int              grp_total [4];
    int              grp_done [4];
    int              grp_err [4];
    string           grp_name [4];

    bpf_exec #(.REG_STAGE(REG_STAGE)) bpf_exec_i (
        .clk(clk), .reset_i(reset_i), .in_valid_i(in_valid_i), .in_ready_o(in_ready_o),
        .opcode_i(opcode_i), .jt_i(jt_i), .jf_i(jf_i), .k_i(k_i), .a_i(a_i), .x_i(x_i),
        .pc_i(pc_i), .out_valid_o(out_valid_o), .out_ready_i(out_ready_i),
        .out_a_o(out_a_o), .out_pc_o(out_pc_o), .out_taken_o(out_taken_o),
        .out_unsup_o(out_unsup_o)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;                     // 20 ns period
    end

    function automatic logic [31:0] xorshift32(input logic [31:0] s);
        logic [31:0] v;
        v = s ^ (s << 13);
        v = v ^ (v >> 17);
        return v ^ (v << 5);
    endfunction

    function automatic logic [31:0] pattern_word(input int p, input int c);
        return pat_mem[p*NCOL + c];
    endfunction

    // Groups follow the class and op field: 0 ALU, 1 sentinel ops, 2 conditional, 3 JA
    function automatic int group_of(input logic [OPC_W-1:0] opc);
        logic [OP_W-1:0] op;
        op = opc[OP_LSB +: OP_W];
        if (opc[CLS_W-1:0] == CLS_JMP) begin
            return (op == JMP_JA) ? 3 : 2;
        end
        return (op == ALU_MUL || op == ALU_DIV || op == ALU_MOD) ? 1 : 0;
    endfunction

    task automatic check_eq(input string name, input logic [31:0] expected,
                            input logic [31:0] actual);
        checks++;
        if (actual !== expected) begin
            errors++;
            $display("[ERROR] %s: expected %h, actual %h", name, expected, actual);
        end
    endtask

    // Called 2 ns after the rising edge
    task automatic drive_cycle();
        int p;
        rng = xorshift32(rng);
        out_ready_i = (rng[1:0] != 2'b00);          // Consumer stalls about one cycle in four
        if (!offering && sent < n_pat && rng[4:2] != 3'b000) begin
            offering = 1'b1;                        // Some cycles leave a bubble on the input
        end
        p = offering ? sent : 0;                    // Idle cycles repeat a harmless payload
        in_valid_i = offering;
        opcode_i   = OPC_W'(pattern_word(p, C_OPC));
        jt_i       = OFS_W'(pattern_word(p, C_JT));
        jf_i       = OFS_W'(pattern_word(p, C_JF));
        k_i        = pattern_word(p, C_K);
        a_i        = pattern_word(p, C_A);
        x_i        = pattern_word(p, C_X);
        pc_i       = pattern_word(p, C_PC);
    endtask

    // Results leave in order, so the oldest expected entry is the one to compare
    task automatic check_result();
        int    g;
        int    e0;
        string t;
        g  = group_of(OPC_W'(pattern_word(recv, C_OPC)));
        e0 = errors;
        t  = $sformatf("%s[%0d]", grp_name[g], recv);
        check_eq($sformatf("%s a", t), pattern_word(recv, C_EA), out_a_o);
        check_eq($sformatf("%s pc", t), pattern_word(recv, C_EPC), out_pc_o);
        check_eq($sformatf("%s taken", t), pattern_word(recv, C_ET), {31'b0, out_taken_o});
        check_eq($sformatf("%s unsup", t), pattern_word(recv, C_EU), {31'b0, out_unsup_o});
        grp_done[g]++;
        if (errors != e0) begin
            grp_err[g]++;
        end
        recv++;
        if (grp_done[g] == grp_total[g]) begin
            $display("%s: %0d patterns checked, %0d with errors, %s", grp_name[g],
                     grp_total[g], grp_err[g], (grp_err[g] == 0) ? "ok" : "fail");
        end
    endtask

    // Mid cycle, both sides are settled and the next edge's transfers are known
    task automatic sample_cycle();
        int e0;
        e0 = errors;
        if (stalled) begin
            check_eq($sformatf("stall[%0d] valid", recv), 32'd1, {31'b0, out_valid_o});
            check_eq($sformatf("stall[%0d] a", recv), held_a, out_a_o);
            check_eq($sformatf("stall[%0d] pc", recv), held_pc, out_pc_o);
            check_eq($sformatf("stall[%0d] flags", recv), {30'b0, held_flags},
                     {30'b0, out_taken_o, out_unsup_o});
        end
        hs_err += errors - e0;
        if (in_valid_i && in_ready_o) begin
            sent++;
            offering = 1'b0;
        end
        if (out_valid_o && out_ready_i) begin
            check_result();
        end
        stalled    = out_valid_o && !out_ready_i;
        held_a     = out_a_o;
        held_pc    = out_pc_o;
        held_flags = {out_taken_o, out_unsup_o};
    endtask

    initial begin : watchdog
        wait (loaded);
        repeat (n_pat * 40 + 100) begin
            @(posedge clk);
        end
        $display("Timeout: results stalled with %0d of %0d received", recv, n_pat);
        $display("TESTS FAILED");
        $finish;
    end

    initial begin
        int e0;
        reset_i = 1'b1;
        in_valid_i = 1'b0;
        opcode_i = '0;
        jt_i = '0;
        jf_i = '0;
        k_i = '0;
        a_i = '0;
        x_i = '0;
        pc_i = '0;
        out_ready_i = 1'b0;
        rng = 32'd94928;
        offering = 1'b0;
        stalled = 1'b0;
        held_a = '0;
        held_pc = '0;
        held_flags = '0;
        n_pat = 0;
        sent = 0;
        recv = 0;
        errors = 0;
        checks = 0;
        hs_err = 0;
        grp_name[0] = "alu ops";
        grp_name[1] = "unsupported ops";
        grp_name[2] = "conditional jumps";
        grp_name[3] = "ja";
        for (int i = 0; i < 4; i++) begin
            grp_total[i] = 0;
            grp_done[i] = 0;
            grp_err[i] = 0;
        end

        // Upper opcode bits set mark the words the file did not overwrite
        for (int i = 0; i < NCOL*MAX_PAT; i++) begin
            pat_mem[i] = 32'hFFFF_0000 | 32'(i);
        end
        $readmemh("verif/bpf_exec_patterns.hex", pat_mem);
        while (n_pat < MAX_PAT && (pattern_word(n_pat, C_OPC) >> 16) == 32'd0) begin
            grp_total[group_of(OPC_W'(pattern_word(n_pat, C_OPC)))]++;
            n_pat++;
        end
        if (n_pat == 0) begin
            $display("No patterns could be read from verif/bpf_exec_patterns.hex");
        end
        loaded = 1'b1;

        repeat (2) @(posedge clk);
        #2;
        reset_i = 1'b0;
        @(negedge clk);
        check_eq("reset out_valid", 32'd0, {31'b0, out_valid_o});
        $display("reset: out_valid low before any input, %s", (errors == 0) ? "ok" : "fail");

        while (recv < n_pat) begin
            @(posedge clk);
            #2;
            drive_cycle();
            @(negedge clk);
            sample_cycle();
        end

        // Nothing may follow the last result
        repeat (4) begin
            @(posedge clk);
            #2;
            in_valid_i = 1'b0;
            out_ready_i = 1'b1;
            @(negedge clk);
            e0 = errors;
            check_eq("drain out_valid", 32'd0, {31'b0, out_valid_o});
            check_eq("inputs accepted", 32'(n_pat), 32'(sent));
            hs_err += errors - e0;
        end
        $display("handshake: %0d results in order, %0d stall or drain errors, %s",
                 recv, hs_err, (hs_err == 0) ? "ok" : "fail");

        $display("Summary: %0d checks, %0d errors, %0d of %0d results received",
                 checks, errors, recv, n_pat);
        if (errors == 0 && n_pat > 0) begin
            $display("TESTS PASSED");
        end else begin
            $display("TESTS FAILED");
        end
        $finish;
    end

endmodule

// File: design/bpf_exec.sv
`timescale 1ns/10ps

module bpf_exec
    import bpf_pkg::*;
#(
    parameter int REG_STAGE = 1            // One extra stage in both parallel units
) (
    input  logic             clk,
    input  logic             reset_i,
    input  logic             in_valid_i,
    output logic             in_ready_o,
    input  logic [OPC_W-1:0] opcode_i,
    input  logic [OFS_W-1:0] jt_i,
    input  logic [OFS_W-1:0] jf_i,
    input  logic [XLEN-1:0]  k_i,
    input  logic [XLEN-1:0]  a_i,
    input  logic [XLEN-1:0]  x_i,
    input  logic [XLEN-1:0]  pc_i,
    output logic             out_valid_o,
    input  logic             out_ready_i,
    output logic [XLEN-1:0]  out_a_o,
    output logic [XLEN-1:0]  out_pc_o,
    output logic             out_taken_o,
    output logic             out_unsup_o
);

    logic            stage_en;             // Shared enable keeps both units aligned
    logic            alu_vld;
    logic [XLEN-1:0] alu_a;
    logic [XLEN-1:0] alu_res;
    logic            alu_unsup;
    logic            br_is_jmp;
    logic            br_taken;
    logic [XLEN-1:0] br_next_pc;

    assign in_ready_o = stage_en;

    bpf_alu #(.REG_STAGE(REG_STAGE)) bpf_alu_i (
        .clk(clk), .reset_i(reset_i), .en_i(stage_en), .valid_i(in_valid_i),
        .opcode_i(opcode_i), .a_i(a_i), .x_i(x_i), .k_i(k_i),
        .vld_o(alu_vld), .a_o(alu_a), .res_o(alu_res), .unsup_o(alu_unsup)
    );

    bpf_branch #(.REG_STAGE(REG_STAGE)) bpf_branch_i (
        .clk(clk), .en_i(stage_en), .opcode_i(opcode_i), .jt_i(jt_i), .jf_i(jf_i),
        .k_i(k_i), .a_i(a_i), .x_i(x_i), .pc_i(pc_i),
        .is_jmp_o(br_is_jmp), .taken_o(br_taken), .next_pc_o(br_next_pc)
    );

    // Result register and handshake
    bpf_commit bpf_commit_i (
        .clk(clk), .reset_i(reset_i), .alu_vld_i(alu_vld), .a_i(alu_a),
        .alu_res_i(alu_res), .alu_unsup_i(alu_unsup), .is_jmp_i(br_is_jmp),
        .taken_i(br_taken), .next_pc_i(br_next_pc), .out_ready_i(out_ready_i),
        .stage_en_o(stage_en), .out_valid_o(out_valid_o), .out_a_o(out_a_o),
        .out_pc_o(out_pc_o), .out_taken_o(out_taken_o), .out_unsup_o(out_unsup_o)
    );

endmodule

// File: design/bpf_commit.sv
`timescale 1ns/10ps

module bpf_commit
    import bpf_pkg::*;
(
    input  logic            clk,
    input  logic            reset_i,
    input  logic            alu_vld_i,     // Item waiting in front of the result register
    input  logic [XLEN-1:0] a_i,           // Accumulator forwarded by bpf_alu
    input  logic [XLEN-1:0] alu_res_i,
    input  logic            alu_unsup_i,
    input  logic            is_jmp_i,
    input  logic            taken_i,
    input  logic [XLEN-1:0] next_pc_i,
    input  logic            out_ready_i,
    output logic            stage_en_o,    // Upstream stage may load, also in_ready_o
    output logic            out_valid_o,
    output logic [XLEN-1:0] out_a_o,
    output logic [XLEN-1:0] out_pc_o,
    output logic            out_taken_o,
    output logic            out_unsup_o
);

    logic            load;                 // Result register can take a new item
    logic            capture;              // A real item moves in this cycle
    logic [XLEN-1:0] a_new;

    // The register is free when empty or when its item leaves on this edge
    assign load    = !out_valid_o || out_ready_i;
    assign capture = load && alu_vld_i;

    // Upstream may advance when its slot is empty or drains into us now
    // With no register stage this also covers the input directly
    assign stage_en_o = !alu_vld_i || load;

    // A jump keeps the accumulator, an ALU instruction replaces it
    assign a_new = is_jmp_i ? a_i : alu_res_i;

    // Output occupancy
    always_ff @(posedge clk) begin
        if (reset_i) begin
            out_valid_o <= 1'b0;
        end else if (load) begin
            out_valid_o <= alu_vld_i;          // Goes low if nothing follows
        end
    end

    // Result payload, only written when an item is really taken in
    always_ff @(posedge clk) begin
        if (capture) begin
            out_a_o     <= a_new;
            out_pc_o    <= next_pc_i;          // Branch unit already gives pc+1 for ALU ops
            out_taken_o <= taken_i;            // Low for anything but a taken jump
            out_unsup_o <= alu_unsup_i;        // Never set for the jump class
        end
    end

    // A stalled result must hold every field until the consumer takes it
    a_hold_stall: assert property (
        @(posedge clk) disable iff (reset_i)
        out_valid_o && !out_ready_i |=>
            out_valid_o && $stable({out_a_o, out_pc_o, out_taken_o, out_unsup_o})
    ) else $error("bpf_commit: output changed while stalled");

endmodule

// File: design/bpf_branch.sv
`timescale 1ns/10ps

module bpf_branch
    import bpf_pkg::*;
#(
    parameter int REG_STAGE = 1            // Must match bpf_alu so both stay in lockstep
) (
    input  logic             clk,
    input  logic             en_i,         // Same stage enable as the arithmetic unit
    input  logic [OPC_W-1:0] opcode_i,
    input  logic [OFS_W-1:0] jt_i,
    input  logic [OFS_W-1:0] jf_i,
    input  logic [XLEN-1:0]  k_i,
    input  logic [XLEN-1:0]  a_i,
    input  logic [XLEN-1:0]  x_i,
    input  logic [XLEN-1:0]  pc_i,
    output logic             is_jmp_o,
    output logic             taken_o,
    output logic [XLEN-1:0]  next_pc_o     // pc+1 for anything that is not a jump
);

    logic [OP_W-1:0] op;
    logic            is_jmp;
    logic [XLEN-1:0] b;
    logic [XLEN:0]   a_minus_b;            // Widened by one bit so the top bit is the borrow
    logic            eq;
    logic            gt;
    logic            ge;
    logic            set;
    logic            taken_c;
    logic [XLEN-1:0] pc1;
    logic [XLEN-1:0] next_pc_c;

    assign op     = opcode_i[OP_LSB +: OP_W];
    assign is_jmp = (opcode_i[CLS_W-1:0] == CLS_JMP);
    assign b      = opcode_i[SRC_X] ? x_i : k_i;

    // Unsigned predicates since classic BPF has no signed compare
    assign eq  = (a_i == b);
    assign gt  = (a_i > b);
    assign a_minus_b = {1'b0, a_i} - {1'b0, b};
    assign ge  = !a_minus_b[XLEN];                 // No borrow means A is at least B
    assign set = |(a_i & b);

    always_comb begin
        taken_c = 1'b0;
        if (is_jmp) begin
            case (op)
                JMP_JA:   taken_c = 1'b1;          // Unconditional
                JMP_JEQ:  taken_c = eq;
                JMP_JGT:  taken_c = gt;
                JMP_JGE:  taken_c = ge;
                JMP_JSET: taken_c = set;
                default:  taken_c = 1'b0;
            endcase
        end
    end

    assign pc1 = pc_i + 1'b1;

    // JA uses the full immediate as offset while conditional jumps use jt or jf
    always_comb begin
        if (!is_jmp) begin
            next_pc_c = pc1;
        end else if (op == JMP_JA) begin
            next_pc_c = pc1 + k_i;
        end else if (taken_c) begin
            next_pc_c = pc1 + {{(XLEN-OFS_W){1'b0}}, jt_i};
        end else begin
            next_pc_c = pc1 + {{(XLEN-OFS_W){1'b0}}, jf_i};
        end
    end

    generate
        if (REG_STAGE != 0) begin : g_stage
            logic            is_jmp_r;
            logic            taken_r;
            logic [XLEN-1:0] next_pc_r;

            // Only payload here because the valid bit lives in bpf_alu
            always_ff @(posedge clk) begin
                if (en_i) begin
                    is_jmp_r  <= is_jmp;
                    taken_r   <= taken_c;
                    next_pc_r <= next_pc_c;
                end
            end

            assign is_jmp_o  = is_jmp_r;
            assign taken_o   = taken_r;
            assign next_pc_o = next_pc_r;
        end else begin : g_comb
            assign is_jmp_o  = is_jmp;
            assign taken_o   = taken_c;
            assign next_pc_o = next_pc_c;
        end
    endgenerate

    // The borrow-based ge has to agree with the eq and gt comparators on every accepted input
    a_ge_consistent: assert property (
        @(posedge clk) en_i && ge |-> (eq || gt)
    ) else $error("bpf_branch: ge set without eq or gt");

endmodule

// File: design/bpf_alu.sv
`timescale 1ns/10ps

module bpf_alu
    import bpf_pkg::*;
#(
    parameter int REG_STAGE = 1            // Adds one register stage when nonzero
) (
    input  logic             clk,
    input  logic             reset_i,
    input  logic             en_i,         // Optional stage may load this cycle
    input  logic             valid_i,      // Instruction present at the input
    input  logic [OPC_W-1:0] opcode_i,
    input  logic [XLEN-1:0]  a_i,
    input  logic [XLEN-1:0]  x_i,
    input  logic [XLEN-1:0]  k_i,
    output logic             vld_o,        // Valid bit that travels with the result
    output logic [XLEN-1:0]  a_o,          // Accumulator forwarded for jump commits
    output logic [XLEN-1:0]  res_o,
    output logic             unsup_o       // MUL, DIV or MOD in the ALU class
);

    logic [OP_W-1:0] op;
    logic            is_alu;
    logic [XLEN-1:0] b;
    logic            big_shift;
    logic [XLEN-1:0] res_c;
    logic            unsup_c;

    assign op     = opcode_i[OP_LSB +: OP_W];
    assign is_alu = (opcode_i[CLS_W-1:0] == CLS_ALU);
    assign b      = opcode_i[SRC_X] ? x_i : k_i;   // Second operand is X or the immediate

    // Any set bit above the shift field means a shift of 32 or more
    assign big_shift = |b[XLEN-1:SH_W];

    always_comb begin
        res_c = '0;                                 // Undefined op codes give zero
        case (op)
            ALU_ADD: res_c = a_i + b;
            ALU_SUB: res_c = a_i - b;
            ALU_MUL: res_c = SENT_MUL;
            ALU_DIV: res_c = SENT_DIV;
            ALU_OR:  res_c = a_i | b;
            ALU_AND: res_c = a_i & b;
            ALU_LSH: res_c = big_shift ? '0 : (a_i << b[SH_W-1:0]);
            ALU_RSH: res_c = big_shift ? '0 : (a_i >> b[SH_W-1:0]);
            ALU_NEG: res_c = ~a_i;                  // Complement, not two's negation
            ALU_MOD: res_c = SENT_MOD;
            ALU_XOR: res_c = a_i ^ b;
            default: res_c = '0;
        endcase
    end

    // Sentinel ops only count as unsupported when the class really is ALU
    assign unsup_c = is_alu && ((op == ALU_MUL) || (op == ALU_DIV) || (op == ALU_MOD));

    generate
        if (REG_STAGE != 0) begin : g_stage
            logic            vld_r;
            logic [XLEN-1:0] a_r;
            logic [XLEN-1:0] res_r;
            logic            unsup_r;

            // Stage occupancy, cleared by reset
            always_ff @(posedge clk) begin
                if (reset_i) begin
                    vld_r <= 1'b0;
                end else if (en_i) begin
                    vld_r <= valid_i;               // Empties when nothing new arrives
                end
            end

            // Payload follows the same enable as the valid bit
            always_ff @(posedge clk) begin
                if (en_i) begin
                    a_r     <= a_i;
                    res_r   <= res_c;
                    unsup_r <= unsup_c;
                end
            end

            assign vld_o   = vld_r;
            assign a_o     = a_r;
            assign res_o   = res_r;
            assign unsup_o = unsup_r;
        end else begin : g_comb
            // Straight through, the commit register is the only stage
            assign vld_o   = valid_i;
            assign a_o     = a_i;
            assign res_o   = res_c;
            assign unsup_o = unsup_c;
        end
    endgenerate

    // The valid bit and its enable steer the whole pipeline and must stay known
    a_vld_known: assert property (
        @(posedge clk) disable iff (reset_i)
        !$isunknown({vld_o, en_i})
    ) else $error("bpf_alu: valid or stage enable is unknown");

endmodule

// File: design/bpf_pkg.sv
package bpf_pkg;

    // Data path and instruction field widths
    localparam int XLEN  = 32;             // A, X, k, result and program counter
    localparam int OPC_W = 16;             // Classic BPF opcode width
    localparam int OFS_W = 8;              // Conditional jump offsets jt and jf
    localparam int CLS_W = 3;              // Class code sits in opcode bits 2 to 0
    localparam int OP_W  = 4;              // Operation field width
    localparam int OP_LSB = 4;             // Operation field sits in opcode bits 7 to 4
    localparam int SRC_X = 3;              // Opcode bit that picks X over k as operand B
    localparam int SH_W  = $clog2(XLEN);   // Bits of B that form a legal shift amount

    // Instruction classes handled by this execute stage
    localparam logic [CLS_W-1:0] CLS_ALU = 3'd4;
    localparam logic [CLS_W-1:0] CLS_JMP = 3'd5;

    // ALU operations, same encoding as the classic BPF op field
    localparam logic [OP_W-1:0] ALU_ADD = 4'd0;
    localparam logic [OP_W-1:0] ALU_SUB = 4'd1;
    localparam logic [OP_W-1:0] ALU_MUL = 4'd2;   // Not implemented, returns a sentinel
    localparam logic [OP_W-1:0] ALU_DIV = 4'd3;   // Not implemented, returns a sentinel
    localparam logic [OP_W-1:0] ALU_OR  = 4'd4;
    localparam logic [OP_W-1:0] ALU_AND = 4'd5;
    localparam logic [OP_W-1:0] ALU_LSH = 4'd6;
    localparam logic [OP_W-1:0] ALU_RSH = 4'd7;
    localparam logic [OP_W-1:0] ALU_NEG = 4'd8;   // Bitwise complement of A
    localparam logic [OP_W-1:0] ALU_MOD = 4'd9;   // Not implemented, returns a sentinel
    localparam logic [OP_W-1:0] ALU_XOR = 4'd10;

    // Jump operations share the op field with the ALU view
    localparam logic [OP_W-1:0] JMP_JA   = 4'd0;
    localparam logic [OP_W-1:0] JMP_JEQ  = 4'd1;
    localparam logic [OP_W-1:0] JMP_JGT  = 4'd2;
    localparam logic [OP_W-1:0] JMP_JGE  = 4'd3;
    localparam logic [OP_W-1:0] JMP_JSET = 4'd4;

    // Result words for operations the unit does not implement
    localparam logic [XLEN-1:0] SENT_MUL = 32'hCAFE_DEAD;
    localparam logic [XLEN-1:0] SENT_DIV = 32'hDEAD_BEEF;
    localparam logic [XLEN-1:0] SENT_MOD = 32'hBEEF_CAFE;

endpackage
